// File: vlog.f
design/cp0Pkg.sv
design/cp0AddrDecode.sv
design/cp0Timer.sv
design/excState.sv
design/intrUnit.sv
design/cp0Top.sv
tests/tbClock.sv
tests/cp0Tb.sv

// File: Makefile
SIM = obj_dir/cp0Sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module cp0Tb -f vlog.f -Mdir obj_dir -o cp0Sim

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// File: tests/cp0Tb.sv
/* CP0 testbench
   Random register, exception, interrupt and timer traffic checked against a model */
`timescale 1ns/1ps

module cp0Tb;

    localparam int HwIntCount    = 6;
    localparam int NumWrites     = 40;
    localparam int NumExc        = 60;
    localparam int NumIntr       = 60;
    localparam int NumTimer      = 4;
    localparam int PollLimit     = 20;
    localparam int PlannedCycles = 40 + NumWrites * 3 + NumExc * 8 + NumIntr
                                   + NumTimer * (PollLimit + 8);
    localparam cp0Pkg::word_t StatusMask = 32'h1040_FF17; // CU0 BEV IM UM ERL EXL IE

    logic                  clk;
    logic                  rst;
    cp0Pkg::regAddr_t      regAddr;
    logic                  wrEn;
    cp0Pkg::word_t         wrData;
    logic                  excFlag;
    cp0Pkg::excType_t      excType;
    cp0Pkg::word_t         pc;
    cp0Pkg::word_t         badAddr;
    logic [1:0]            cpNum;
    logic                  excStore;
    logic                  inSlot;
    logic [HwIntCount-1:0] hwIntr;
    cp0Pkg::word_t         rdData;
    logic                  excIntr;
    logic                  userMode;

    logic [31:0]   lcgState;
    cp0Pkg::word_t statusM;
    cp0Pkg::word_t epcM;
    cp0Pkg::word_t badM;
    cp0Pkg::word_t compareM;
    logic          bdM;
    logic [1:0]    ceM;
    logic          ivM;
    logic [1:0]    softM;
    logic [4:0]    codeM;
    logic [5:0]    ipHwM;  // Registered IP[7..2]

    tbClock #(.PeriodNs(40), .ResetCycles(3)) uClock (.clk_o(clk), .rst_o(rst));

    cp0Top #(
        .HwIntCount  (HwIntCount),
        .CountDivLog2(1)
    ) DUT (
        .clk       (clk),
        .rst       (rst),
        .regAddr_i (regAddr),
        .wrEn_i    (wrEn),
        .wrData_i  (wrData),
        .excFlag_i (excFlag),
        .excType_i (excType),
        .pc_i      (pc),
        .badAddr_i (badAddr),
        .cpNum_i   (cpNum),
        .excStore_i(excStore),
        .inSlot_i  (inSlot),
        .hwIntr_i  (hwIntr),
        .rdData_o  (rdData),
        .excIntr_o (excIntr),
        .userMode_o(userMode)
    );

    function automatic logic [31:0] randWord();
        logic [31:0] hi;
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        hi = lcgState;
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return {hi[31:16], lcgState[31:16]}; // Upper halves only
    endfunction

    function automatic cp0Pkg::word_t expectedCause();
        cp0Pkg::word_t w;
        w = '0;
        w[31]    = bdM;
        w[29:28] = ceM;
        w[23]    = ivM;
        w[15:10] = ipHwM;
        w[9:8]   = softM;
        w[6:2]   = codeM;
        return w;
    endfunction

    function automatic logic expectedIntr();
        logic [7:0] ip;
        ip = {ipHwM, softM};
        return (|(ip & statusM[15:8])) & statusM[0] & ~statusM[1] & ~statusM[2];
    endfunction

    function automatic logic expectedUser();
        return statusM[4] & ~statusM[1] & ~statusM[2];
    endfunction

    function automatic cp0Pkg::regAddr_t pickReg(input logic [31:0] n);
        case (n)
            0:       return cp0Pkg::RegStatus;
            1:       return cp0Pkg::RegCause;
            2:       return cp0Pkg::RegEpc;
            3:       return cp0Pkg::RegBadVAddr;
            default: return cp0Pkg::RegCompare;
        endcase
    endfunction

    task automatic checkWord(input string name, input cp0Pkg::word_t expVal,
                             input cp0Pkg::word_t actVal);
        if (actVal !== expVal) begin
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expVal, actVal);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic checkFlag(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            $display("FAILED at %0t ns: %s expected %b, got %b", $time, name, expVal, actVal);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic checkWordMin(input string name, input cp0Pkg::word_t minVal,
                                input cp0Pkg::word_t actVal);
        if (actVal < minVal) begin
            $display("FAILED at %0t ns: %s expected at least %h, got %h",
                     $time, name, minVal, actVal);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #5;
    endtask

    task automatic setIdle();
        wrEn    = 1'b0;
        excFlag = 1'b0;
        excType = cp0Pkg::ExcIntr;
    endtask

    task automatic readCheck(input cp0Pkg::regAddr_t a, input cp0Pkg::word_t expVal,
                             input string name);
        regAddr = a;
        setIdle();
        #10;
        checkWord(name, expVal, rdData);
        nextCycle();
    endtask

    task automatic writeReg(input cp0Pkg::regAddr_t a, input cp0Pkg::word_t d);
        regAddr = a;
        wrData  = d;
        excFlag = 1'b0;
        wrEn    = 1'b1;
        nextCycle();
        wrEn = 1'b0;
    endtask

    task automatic applyWrite(input cp0Pkg::regAddr_t a, input cp0Pkg::word_t d);
        case (a)
            cp0Pkg::RegStatus:   statusM = d & StatusMask;
            cp0Pkg::RegCause: begin
                ivM   = d[23];
                softM = d[9:8];
            end
            cp0Pkg::RegEpc:      epcM = d;
            cp0Pkg::RegBadVAddr: badM = d;
            cp0Pkg::RegCompare:  compareM = d;
            default: ;
        endcase
    endtask

    task automatic writeAndModel(input cp0Pkg::regAddr_t a, input cp0Pkg::word_t d);
        writeReg(a, d);
        applyWrite(a, d);
    endtask

    // Model of exception entry and ERET from the driven request
    task automatic applyException();
        if (excType == cp0Pkg::ExcEret) begin
            statusM[1] = 1'b0;
        end else begin
            if (!statusM[1]) begin
                epcM = inSlot ? pc - 32'd4 : pc;
                bdM  = inSlot;
            end
            statusM[1] = 1'b1;
        end
        case (excType)
            cp0Pkg::ExcIntr: codeM = 5'd0;
            cp0Pkg::ExcCpU: begin
                codeM = 5'd11;
                ceM   = cpNum;
            end
            cp0Pkg::ExcRI:   codeM = 5'd10;
            cp0Pkg::ExcOv:   codeM = 5'd12;
            cp0Pkg::ExcTrap: codeM = 5'd13;
            cp0Pkg::ExcSysC: codeM = 5'd8;
            cp0Pkg::ExcBp:   codeM = 5'd9;
            cp0Pkg::ExcAdE: begin
                codeM = excStore ? 5'd5 : 5'd4;
                badM  = badAddr;
            end
            default: ;
        endcase
    endtask

    task automatic checkState();
        readCheck(cp0Pkg::RegStatus, statusM, "Status");
        readCheck(cp0Pkg::RegCause, expectedCause(), "Cause");
        readCheck(cp0Pkg::RegEpc, epcM, "EPC");
        readCheck(cp0Pkg::RegBadVAddr, badM, "BadVAddr");
        readCheck(cp0Pkg::RegCompare, compareM, "Compare");
    endtask

    initial begin
        #(PlannedCycles * 80);
        $display("Watchdog expired after %0d clock cycles", PlannedCycles * 2);
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        cp0Pkg::word_t r;
        cp0Pkg::word_t c;
        cp0Pkg::word_t cnt;
        int            polls;
        logic          found;

        regAddr  = '0;
        wrData   = '0;
        pc       = '0;
        badAddr  = '0;
        cpNum    = 2'b00;
        excStore = 1'b0;
        inSlot   = 1'b0;
        hwIntr   = '0;
        setIdle();
        lcgState = 32'd27148;
        statusM  = 32'h0040_0004;
        epcM     = '0;
        badM     = '0;
        compareM = '0;
        bdM      = 1'b0;
        ceM      = 2'b00;
        ivM      = 1'b0;
        softM    = 2'b00;
        codeM    = 5'd0;
        ipHwM    = '0;

        wait (rst === 1'b0);
        nextCycle();

        // Reset values
        checkState();
        readCheck(cp0Pkg::RegPrId, 32'h0001_8066, "PrId");
        regAddr = 5'd3;
        #10;
        checkWord("unused register", 32'h0, rdData);
        checkFlag("excIntr_o", 1'b0, excIntr);
        checkFlag("userMode_o", 1'b0, userMode);
        nextCycle();

        // Write and read back
        for (int i = 0; i < NumWrites; i++) begin
            r = randWord();
            case (randWord() % 6)
                0: begin
                    writeAndModel(cp0Pkg::RegStatus, r);
                    readCheck(cp0Pkg::RegStatus, statusM, "Status");
                end
                1: begin
                    writeAndModel(cp0Pkg::RegCause, r);
                    readCheck(cp0Pkg::RegCause, expectedCause(), "Cause");
                end
                2: begin
                    writeAndModel(cp0Pkg::RegEpc, r);
                    readCheck(cp0Pkg::RegEpc, epcM, "EPC");
                end
                3: begin
                    writeAndModel(cp0Pkg::RegBadVAddr, r);
                    readCheck(cp0Pkg::RegBadVAddr, badM, "BadVAddr");
                end
                4: begin
                    writeAndModel(cp0Pkg::RegCompare, r | 32'h8000_0000); // Out of Count's reach
                    readCheck(cp0Pkg::RegCompare, compareM, "Compare");
                end
                default: begin
                    writeReg(cp0Pkg::RegCount, r & 32'h3FFF_FFFF);
                    readCheck(cp0Pkg::RegCount, r & 32'h3FFF_FFFF, "Count");
                end
            endcase
        end
        writeAndModel(cp0Pkg::RegCompare, 32'h0);

        // Exceptions, ERET and lost writes
        for (int i = 0; i < NumExc; i++) begin
            if (randWord() % 4 == 0)
                writeAndModel(cp0Pkg::RegStatus, randWord() & ~32'h6);
            r        = randWord();
            regAddr  = pickReg(randWord() % 5);
            wrData   = randWord();
            wrEn     = r[0];
            excFlag  = 1'b1;
            excType  = cp0Pkg::excType_t'(4'(randWord() % 9));
            pc       = randWord() & ~32'h3;
            badAddr  = randWord();
            cpNum    = r[2:1];
            excStore = r[3];
            inSlot   = r[4];
            nextCycle();
            applyException();
            setIdle();
            checkState();
        end

        // Interrupt lines with random Status and soft bits
        for (int i = 0; i < NumIntr; i++) begin
            r       = randWord();
            hwIntr  = r[HwIntCount-1:0];
            r       = randWord();
            regAddr = (i % 3 == 0) ? cp0Pkg::RegStatus : cp0Pkg::RegCause;
            wrData  = (i % 3 == 0 && r[31]) ? (r & ~32'h6) : r;
            wrEn    = (i % 3 != 2);
            #10;
            checkFlag("excIntr_o", expectedIntr(), excIntr);
            checkFlag("userMode_o", expectedUser(), userMode);
            if (!wrEn)
                checkWord("Cause", expectedCause(), rdData);
            @(posedge clk);
            ipHwM = hwIntr;
            if (wrEn)
                applyWrite(regAddr, wrData);
            #5;
        end
        hwIntr = '0;
        setIdle();
        nextCycle();
        ipHwM = '0;

        // Count/Compare timer
        for (int t = 0; t < NumTimer; t++) begin
            c = (randWord() & 32'h00FF_FFFF) | 32'h100;
            writeReg(cp0Pkg::RegCount, c - 32'd2);
            writeAndModel(cp0Pkg::RegCompare, c);
            polls = 0;
            found = 1'b0;
            while (!found && polls < PollLimit) begin
                regAddr = cp0Pkg::RegCause;
                #10;
                found = rdData[15];
                polls++;
                nextCycle();
            end
            if (!found) begin
                $display("Timer interrupt never showed in Cause IP7 within %0d cycles", PollLimit);
                $display("Test failed");
                $fatal(1);
            end
            regAddr = cp0Pkg::RegCount;
            #10;
            cnt = rdData;
            checkWordMin("Count", c, cnt);
            nextCycle();
            writeAndModel(cp0Pkg::RegCompare, 32'h0); // Acknowledge
            nextCycle();
            readCheck(cp0Pkg::RegCause, expectedCause(), "Cause");
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: tests/tbClock.sv
/* Testbench clock and reset source */
`timescale 1ns/1ps

module tbClock #(
    parameter int PeriodNs    = 40,
    parameter int ResetCycles = 3
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PeriodNs / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        #(ResetCycles * PeriodNs) rst_o = 1'b0; // Released on a falling edge
    end

endmodule

// File: design/cp0Top.sv
/* CP0 top level
   Connects decode, timer, exception state and interrupt unit */
`timescale 1ns/1ps

module cp0Top #(
    parameter int HwIntCount   = 6,
    parameter int CountDivLog2 = 1
) (
    input  logic                  clk,
    input  logic                  rst,
    input  cp0Pkg::regAddr_t      regAddr_i,
    input  logic                  wrEn_i,
    input  cp0Pkg::word_t         wrData_i,
    input  logic                  excFlag_i,
    input  cp0Pkg::excType_t      excType_i,
    input  cp0Pkg::word_t         pc_i,
    input  cp0Pkg::word_t         badAddr_i,
    input  logic [1:0]            cpNum_i,
    input  logic                  excStore_i,
    input  logic                  inSlot_i,
    input  logic [HwIntCount-1:0] hwIntr_i,
    output cp0Pkg::word_t         rdData_o,
    output logic                  excIntr_o,
    output logic                  userMode_o
);

    logic          wrCount;
    logic          wrCompare;
    logic          wrStatus;
    logic          wrCause;
    logic          wrEpc;
    logic          wrBadVAddr;
    logic          timerIrq;
    cp0Pkg::word_t countValue;
    cp0Pkg::word_t compareValue;
    cp0Pkg::word_t statusWord;
    cp0Pkg::word_t causeWord;
    cp0Pkg::word_t epcValue;
    cp0Pkg::word_t badVAddrValue;
    logic [7:0]    ipBits;
    logic [1:0]    softIp;

    cp0AddrDecode uDecode (
        .regAddr_i      (regAddr_i),
        .wrEn_i         (wrEn_i),
        .excFlag_i      (excFlag_i),
        .countValue_i   (countValue),
        .compareValue_i (compareValue),
        .statusWord_i   (statusWord),
        .causeWord_i    (causeWord),
        .epcValue_i     (epcValue),
        .badVAddrValue_i(badVAddrValue),
        .wrCount_o      (wrCount),
        .wrCompare_o    (wrCompare),
        .wrStatus_o     (wrStatus),
        .wrCause_o      (wrCause),
        .wrEpc_o        (wrEpc),
        .wrBadVAddr_o   (wrBadVAddr),
        .rdData_o       (rdData_o)
    );

    cp0Timer #(
        .CountDivLog2(CountDivLog2)
    ) uTimer (
        .clk           (clk),
        .rst           (rst),
        .wrCount_i     (wrCount),
        .wrCompare_i   (wrCompare),
        .wrData_i      (wrData_i),
        .countValue_o  (countValue),
        .compareValue_o(compareValue),
        .timerIrq_o    (timerIrq)
    );

    excState uExcState (
        .clk            (clk),
        .rst            (rst),
        .wrStatus_i     (wrStatus),
        .wrCause_i      (wrCause),
        .wrEpc_i        (wrEpc),
        .wrBadVAddr_i   (wrBadVAddr),
        .wrData_i       (wrData_i),
        .excFlag_i      (excFlag_i),
        .excType_i      (excType_i),
        .pc_i           (pc_i),
        .badAddr_i      (badAddr_i),
        .cpNum_i        (cpNum_i),
        .excStore_i     (excStore_i),
        .inSlot_i       (inSlot_i),
        .ipBits_i       (ipBits),
        .statusWord_o   (statusWord),
        .causeWord_o    (causeWord),
        .epcValue_o     (epcValue),
        .badVAddrValue_o(badVAddrValue),
        .softIp_o       (softIp)
    );

    intrUnit #(
        .HwIntCount(HwIntCount)
    ) uIntr (
        .clk         (clk),
        .rst         (rst),
        .hwIntr_i    (hwIntr_i),
        .timerIrq_i  (timerIrq),
        .softIp_i    (softIp),
        .statusWord_i(statusWord),
        .ipBits_o    (ipBits),
        .excIntr_o   (excIntr_o),
        .userMode_o  (userMode_o)
    );

endmodule

// File: design/intrUnit.sv
/* CP0 interrupt unit
   Samples the interrupt lines into Cause IP and derives the interrupt and user-mode flags */
`timescale 1ns/1ps

module intrUnit #(
    parameter int HwIntCount = 6
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [HwIntCount-1:0] hwIntr_i,
    input  logic                  timerIrq_i,
    input  logic [1:0]            softIp_i,
    input  cp0Pkg::word_t         statusWord_i,
    output logic [7:0]            ipBits_o,
    output logic                  excIntr_o,
    output logic                  userMode_o
);

    logic [5:0] hwLines;
    logic [5:0] hwIp;   // IP[7..2]
    logic       noExcErl;
    logic [7:0] imBits;

    assign hwLines = 6'(hwIntr_i);

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            hwIp <= '0;
        else
            hwIp <= {hwLines[5] | timerIrq_i, hwLines[4:0]}; // Timer shares IP7
    end

    assign ipBits_o = {hwIp, softIp_i};

    assign imBits   = statusWord_i[cp0Pkg::StatusImHi:cp0Pkg::StatusImLo];
    assign noExcErl = ~statusWord_i[cp0Pkg::StatusExlBit] & ~statusWord_i[cp0Pkg::StatusErlBit];

    assign excIntr_o  = (|(ipBits_o & imBits)) & statusWord_i[cp0Pkg::StatusIeBit] & noExcErl;
    assign userMode_o = statusWord_i[cp0Pkg::StatusUmBit] & noExcErl;

endmodule

// File: design/excState.sv
/* CP0 exception state
   Status, Cause, EPC and BadVAddr with exception entry, ERET and software writes */
`timescale 1ns/1ps

module excState (
    input  logic             clk,
    input  logic             rst,
    input  logic             wrStatus_i,
    input  logic             wrCause_i,
    input  logic             wrEpc_i,
    input  logic             wrBadVAddr_i,
    input  cp0Pkg::word_t    wrData_i,
    input  logic             excFlag_i,
    input  cp0Pkg::excType_t excType_i,
    input  cp0Pkg::word_t    pc_i,
    input  cp0Pkg::word_t    badAddr_i,
    input  logic [1:0]       cpNum_i,
    input  logic             excStore_i,
    input  logic             inSlot_i,
    input  logic [7:0]       ipBits_i,
    output cp0Pkg::word_t    statusWord_o,
    output cp0Pkg::word_t    causeWord_o,
    output cp0Pkg::word_t    epcValue_o,
    output cp0Pkg::word_t    badVAddrValue_o,
    output logic [1:0]       softIp_o
);

    logic             statusCu0;
    logic             statusBev;
    logic [7:0]       statusIm;
    logic             statusUm;
    logic             statusErl;
    logic             statusExl;
    logic             statusIe;
    logic             causeBd;
    logic [1:0]       causeCe;
    logic             causeIv;
    logic [1:0]       causeSoftIp;
    cp0Pkg::excCode_t causeExcCode;
    cp0Pkg::word_t    epc;
    cp0Pkg::word_t    badVAddr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            statusCu0    <= cp0Pkg::StatusResetValue[cp0Pkg::StatusCu0Bit];
            statusBev    <= cp0Pkg::StatusResetValue[cp0Pkg::StatusBevBit];
            statusIm     <= cp0Pkg::StatusResetValue[cp0Pkg::StatusImHi:cp0Pkg::StatusImLo];
            statusUm     <= cp0Pkg::StatusResetValue[cp0Pkg::StatusUmBit];
            statusErl    <= cp0Pkg::StatusResetValue[cp0Pkg::StatusErlBit];
            statusExl    <= cp0Pkg::StatusResetValue[cp0Pkg::StatusExlBit];
            statusIe     <= cp0Pkg::StatusResetValue[cp0Pkg::StatusIeBit];
            causeBd      <= 1'b0;
            causeCe      <= 2'b00;
            causeIv      <= 1'b0;
            causeSoftIp  <= 2'b00;
            causeExcCode <= cp0Pkg::CodeInt;
            epc          <= '0;
            badVAddr     <= '0;
        end else begin
            if (excFlag_i) begin
                if (excType_i == cp0Pkg::ExcEret) begin
                    statusExl <= 1'b0;
                end else begin
                    if (!statusExl) begin // Nested exceptions keep the first EPC
                        epc     <= inSlot_i ? pc_i - 32'd4 : pc_i;
                        causeBd <= inSlot_i;
                    end
                    statusExl <= 1'b1;
                end

                case (excType_i)
                    cp0Pkg::ExcIntr: causeExcCode <= cp0Pkg::CodeInt;
                    cp0Pkg::ExcCpU: begin
                        causeExcCode <= cp0Pkg::CodeCpU;
                        causeCe      <= cpNum_i;
                    end
                    cp0Pkg::ExcRI:   causeExcCode <= cp0Pkg::CodeRI;
                    cp0Pkg::ExcOv:   causeExcCode <= cp0Pkg::CodeOv;
                    cp0Pkg::ExcTrap: causeExcCode <= cp0Pkg::CodeTr;
                    cp0Pkg::ExcSysC: causeExcCode <= cp0Pkg::CodeSys;
                    cp0Pkg::ExcBp:   causeExcCode <= cp0Pkg::CodeBp;
                    cp0Pkg::ExcAdE: begin
                        causeExcCode <= excStore_i ? cp0Pkg::CodeAdES : cp0Pkg::CodeAdEL;
                        badVAddr     <= badAddr_i;
                    end
                    default: ; // ERET leaves ExcCode alone
                endcase
            end

            if (wrStatus_i) begin
                statusCu0 <= wrData_i[cp0Pkg::StatusCu0Bit];
                statusBev <= wrData_i[cp0Pkg::StatusBevBit];
                statusIm  <= wrData_i[cp0Pkg::StatusImHi:cp0Pkg::StatusImLo];
                statusUm  <= wrData_i[cp0Pkg::StatusUmBit];
                statusErl <= wrData_i[cp0Pkg::StatusErlBit];
                statusExl <= wrData_i[cp0Pkg::StatusExlBit];
                statusIe  <= wrData_i[cp0Pkg::StatusIeBit];
            end
            if (wrCause_i) begin
                causeIv     <= wrData_i[cp0Pkg::CauseIvBit];
                causeSoftIp <= wrData_i[cp0Pkg::CauseIpLo+1:cp0Pkg::CauseIpLo];
            end
            if (wrEpc_i)
                epc <= wrData_i;
            if (wrBadVAddr_i)
                badVAddr <= wrData_i;
        end
    end

    always_comb begin
        statusWord_o = '0;
        statusWord_o[cp0Pkg::StatusCu0Bit] = statusCu0;
        statusWord_o[cp0Pkg::StatusBevBit] = statusBev;
        statusWord_o[cp0Pkg::StatusImHi:cp0Pkg::StatusImLo] = statusIm;
        statusWord_o[cp0Pkg::StatusUmBit]  = statusUm;
        statusWord_o[cp0Pkg::StatusErlBit] = statusErl;
        statusWord_o[cp0Pkg::StatusExlBit] = statusExl;
        statusWord_o[cp0Pkg::StatusIeBit]  = statusIe;
    end

    always_comb begin
        causeWord_o = '0;
        causeWord_o[cp0Pkg::CauseBdBit] = causeBd;
        causeWord_o[cp0Pkg::CauseCeHi:cp0Pkg::CauseCeLo] = causeCe;
        causeWord_o[cp0Pkg::CauseIvBit] = causeIv;
        causeWord_o[cp0Pkg::CauseIpHi:cp0Pkg::CauseIpLo] = ipBits_i; // Soft bits come back here
        causeWord_o[cp0Pkg::CauseExcHi:cp0Pkg::CauseExcLo] = causeExcCode;
    end

    assign epcValue_o      = epc;
    assign badVAddrValue_o = badVAddr;
    assign softIp_o        = causeSoftIp;

    excBlocksWrite: assert property (
        @(posedge clk) disable iff (rst)
        excFlag_i |-> !(wrStatus_i | wrCause_i | wrEpc_i | wrBadVAddr_i)
    ) else $error("Register write strobe active during an exception");

endmodule

// File: design/cp0Timer.sv
/* CP0 Count/Compare timer
   Divided free-running Count, Compare register and timer interrupt latch */
`timescale 1ns/1ps

module cp0Timer #(
    parameter int CountDivLog2 = 1
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          wrCount_i,
    input  logic          wrCompare_i,
    input  cp0Pkg::word_t wrData_i,
    output cp0Pkg::word_t countValue_o,
    output cp0Pkg::word_t compareValue_o,
    output logic          timerIrq_o
);

    localparam int CntW = 32 + CountDivLog2;

    logic [CntW-1:0] countReg; // Low bits are the prescaler
    cp0Pkg::word_t   compareReg;
    logic            timerIrq;
    logic            timerHit;

    assign countValue_o   = countReg[CntW-1 -: 32];
    assign compareValue_o = compareReg;
    assign timerIrq_o     = timerIrq;

    assign timerHit = (compareReg != '0) && (countValue_o == compareReg);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            countReg   <= '0;
            compareReg <= '0;
            timerIrq   <= 1'b0;
        end else begin
            if (wrCount_i)
                countReg <= CntW'(wrData_i) << CountDivLog2; // Prescaler restarts
            else
                countReg <= countReg + 1'b1;

            if (wrCompare_i) begin
                compareReg <= wrData_i;
                timerIrq   <= 1'b0; // Acknowledge
            end else if (timerHit) begin
                timerIrq <= 1'b1;
            end
        end
    end

endmodule

// File: design/cp0AddrDecode.sv
/* CP0 register decode
   Per-register write strobes and the combinational read multiplexer */
`timescale 1ns/1ps

module cp0AddrDecode (
    input  cp0Pkg::regAddr_t regAddr_i,
    input  logic             wrEn_i,
    input  logic             excFlag_i,
    input  cp0Pkg::word_t    countValue_i,
    input  cp0Pkg::word_t    compareValue_i,
    input  cp0Pkg::word_t    statusWord_i,
    input  cp0Pkg::word_t    causeWord_i,
    input  cp0Pkg::word_t    epcValue_i,
    input  cp0Pkg::word_t    badVAddrValue_i,
    output logic             wrCount_o,
    output logic             wrCompare_o,
    output logic             wrStatus_o,
    output logic             wrCause_o,
    output logic             wrEpc_o,
    output logic             wrBadVAddr_o,
    output cp0Pkg::word_t    rdData_o
);

    logic wrOk;

    assign wrOk = wrEn_i & ~excFlag_i; // Exception drops the write

    assign wrCount_o    = wrOk && (regAddr_i == cp0Pkg::RegCount);
    assign wrCompare_o  = wrOk && (regAddr_i == cp0Pkg::RegCompare);
    assign wrStatus_o   = wrOk && (regAddr_i == cp0Pkg::RegStatus);
    assign wrCause_o    = wrOk && (regAddr_i == cp0Pkg::RegCause);
    assign wrEpc_o      = wrOk && (regAddr_i == cp0Pkg::RegEpc);
    assign wrBadVAddr_o = wrOk && (regAddr_i == cp0Pkg::RegBadVAddr);

    always_comb begin
        case (regAddr_i)
            cp0Pkg::RegBadVAddr: rdData_o = badVAddrValue_i;
            cp0Pkg::RegCount:    rdData_o = countValue_i;
            cp0Pkg::RegCompare:  rdData_o = compareValue_i;
            cp0Pkg::RegStatus:   rdData_o = statusWord_i;
            cp0Pkg::RegCause:    rdData_o = causeWord_i;
            cp0Pkg::RegEpc:      rdData_o = epcValue_i;
            cp0Pkg::RegPrId:     rdData_o = cp0Pkg::PrIdValue;
            default:             rdData_o = '0; // Unimplemented numbers
        endcase
    end

endmodule

// File: design/cp0Pkg.sv
/* CP0 shared definitions
   Data types, exception encodings, register numbers and field positions */
package cp0Pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;

    // Exception requests from the pipeline
    typedef enum logic [3:0] {
        ExcIntr = 4'd0,
        ExcCpU  = 4'd1,
        ExcRI   = 4'd2,
        ExcOv   = 4'd3,
        ExcTrap = 4'd4,
        ExcSysC = 4'd5,
        ExcBp   = 4'd6,
        ExcAdE  = 4'd7,
        ExcEret = 4'd8
    } excType_t;

    // Architectural Cause.ExcCode values
    typedef enum logic [4:0] {
        CodeInt  = 5'd0,
        CodeAdEL = 5'd4,
        CodeAdES = 5'd5,
        CodeSys  = 5'd8,
        CodeBp   = 5'd9,
        CodeRI   = 5'd10,
        CodeCpU  = 5'd11,
        CodeOv   = 5'd12,
        CodeTr   = 5'd13
    } excCode_t;

    localparam regAddr_t RegBadVAddr = 5'd8;
    localparam regAddr_t RegCount    = 5'd9;
    localparam regAddr_t RegCompare  = 5'd11;
    localparam regAddr_t RegStatus   = 5'd12;
    localparam regAddr_t RegCause    = 5'd13;
    localparam regAddr_t RegEpc      = 5'd14;
    localparam regAddr_t RegPrId     = 5'd15;

    // Status fields
    localparam int StatusCu0Bit = 28;
    localparam int StatusBevBit = 22;
    localparam int StatusImHi   = 15;
    localparam int StatusImLo   = 8;
    localparam int StatusUmBit  = 4;
    localparam int StatusErlBit = 2;
    localparam int StatusExlBit = 1;
    localparam int StatusIeBit  = 0;

    // Cause fields
    localparam int CauseBdBit  = 31;
    localparam int CauseCeHi   = 29;
    localparam int CauseCeLo   = 28;
    localparam int CauseIvBit  = 23;
    localparam int CauseIpHi   = 15;
    localparam int CauseIpLo   = 8;
    localparam int CauseExcHi  = 6;
    localparam int CauseExcLo  = 2;

    localparam word_t PrIdValue        = 32'h0001_8066;
    localparam word_t StatusResetValue = 32'h0040_0004; // BEV and ERL

endpackage
